// ==== verilog/loader_cfg.svh ====
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// Frame command codes
`define CMD_WRITE 8'd1
`define CMD_LAUNCH 8'd2

// Bytes buffered between QSPI receiver and decoder
`define RX_FIFO_DEPTH 4

// Address bits actually stored by the word memory
`define RAM_AW 10

// Busy window after each memory write, in clk cycles
`define RAM_BUSY_CYCLES 3

`endif

// ==== verilog/loader_pkg.sv ====
`default_nettype none

package loader_pkg;

    // One byte off the QSPI link
    typedef logic [7:0] byte_t;

    // Memory data word
    typedef logic [15:0] word_t;

    // Word address as seen on the memory bus
    typedef logic [21:0] waddr_t;

    // Mapper control word handed over by LAUNCH
    typedef logic [23:0] map_ctrl_t;

    // Frame parser states
    typedef enum logic [1:0] {
        CMD,   // waiting for command byte
        ADDR,  // address or launch word bytes
        DATA   // payload, or draining after launch
    } dec_state_t;

endpackage

`default_nettype wire

// ==== verilog/byte_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
    import loader_pkg::*;

    logic rd_valid;
    logic rd_ready;
    byte_t rd_data;
    logic closed; // chip select inactive

    modport producer (
        output rd_valid,
        output rd_data,
        output closed,
        input rd_ready
    );

    modport consumer (
        input rd_valid,
        input rd_data,
        input closed,
        output rd_ready
    );
endinterface

`default_nettype wire

// ==== verilog/sdram_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sdram_port_if;
    import loader_pkg::*;

    logic req;          // one-cycle pulse
    logic we;
    logic [1:0] wm;     // byte masks, high byte in bit 1
    waddr_t address;
    word_t data_write;
    logic busy;

    modport controller (
        output req,
        output we,
        output wm,
        output address,
        output data_write,
        input busy
    );

    modport memory (
        input req,
        input we,
        input wm,
        input address,
        input data_write,
        output busy
    );
endinterface

`default_nettype wire

// ==== verilog/qspi_byte_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loader_cfg.svh"

module qspi_byte_rx (
    input logic clk,
    input logic reset,
    input logic qspi_sck,
    input logic qspi_cs_n,
    input logic [3:0] qspi_io,
    byte_stream_if.producer stream
);
    import loader_pkg::*;

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [3:0] io_s1, io_s2;
    logic sck_q;
    logic sck_rise;

    logic nib_phase; // high after the upper nibble
    logic [3:0] nib_hi;

    byte_t fifo_mem [DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic push, load, full;

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync <= 2'b00;
            cs_sync <= 2'b11;
            sck_q <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], qspi_sck};
            cs_sync <= {cs_sync[0], qspi_cs_n};
            sck_q <= sck_sync[1];
        end
        io_s1 <= qspi_io;
        io_s2 <= io_s1;
    end

    assign sck_rise = sck_sync[1] && !sck_q;
    assign stream.closed = cs_sync[1];

    // Second nibble of a byte completes it
    assign push = sck_rise && nib_phase && !cs_sync[1];
    assign full = (count == CW'(DEPTH));
    assign load = (count != 0) && (!stream.rd_valid || stream.rd_ready);

    always_ff @(posedge clk) begin
        if (reset || cs_sync[1]) begin
            nib_phase <= 1'b0;
        end else if (sck_rise) begin
            if (!nib_phase) nib_hi <= io_s2;
            nib_phase <= !nib_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            stream.rd_valid <= 1'b0;
        end else begin
            if (push && !full) begin
                fifo_mem[wr_ptr] <= {nib_hi, io_s2};
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end

            // Output register refills whenever it is empty or being taken
            if (load) begin
                stream.rd_data <= fifo_mem[rd_ptr];
                stream.rd_valid <= 1'b1;
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end else if (stream.rd_ready) begin
                stream.rd_valid <= 1'b0;
            end

            case ({push && !full, load})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Host SCK too fast for the decoder
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
endmodule

`default_nettype wire

// ==== verilog/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loader_cfg.svh"

module cmd_decoder (
    input logic clk,
    input logic reset,
    byte_stream_if.consumer stream,
    sdram_port_if.controller ram,
    output loader_pkg::map_ctrl_t launch_word,
    output logic launch_strobe
);
    import loader_pkg::*;

    dec_state_t state;
    byte_t cmd;
    logic [1:0] byte_cnt;
    logic high_byte;  // next data byte is the upper half
    logic first_word; // no increment before the first write

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CMD;
            stream.rd_ready <= 1'b0;
            ram.req <= 1'b0;
            launch_strobe <= 1'b0;
        end else begin
            stream.rd_ready <= 1'b0;
            ram.req <= 1'b0;
            launch_strobe <= 1'b0;

            // Frame ended and nothing left to drain
            if (stream.closed && !stream.rd_valid) begin
                state <= CMD;
            end

            if (stream.rd_valid && !stream.rd_ready) begin
                case (state)
                    CMD: begin
                        stream.rd_ready <= 1'b1;
                        cmd <= stream.rd_data;
                        byte_cnt <= 2'd0;
                        state <= ADDR;
                    end

                    ADDR: begin
                        stream.rd_ready <= 1'b1;
                        case (cmd)
                            `CMD_WRITE: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                // Byte address in, word address kept
                                case (byte_cnt)
                                    2'd0: ram.address[21:15] <= stream.rd_data[6:0];
                                    2'd1: ram.address[14:7] <= stream.rd_data;
                                    default: ram.address[6:0] <= stream.rd_data[7:1];
                                endcase
                                if (byte_cnt == 2'd2) begin
                                    high_byte <= 1'b1;
                                    first_word <= 1'b1;
                                    state <= DATA;
                                end
                            end
                            `CMD_LAUNCH: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                case (byte_cnt)
                                    2'd0: launch_word[23:16] <= stream.rd_data;
                                    2'd1: launch_word[15:8] <= stream.rd_data;
                                    default: launch_word[7:0] <= stream.rd_data;
                                endcase
                                if (byte_cnt == 2'd2) begin
                                    launch_strobe <= 1'b1;
                                    state <= DATA;
                                end
                            end
                            default: ; // unknown command, drop bytes until close
                        endcase
                    end

                    DATA: begin
                        if (!ram.busy) begin
                            stream.rd_ready <= 1'b1;
                            if (cmd == `CMD_WRITE) begin
                                if (high_byte) begin
                                    ram.data_write[15:8] <= stream.rd_data;
                                end else begin
                                    ram.data_write[7:0] <= stream.rd_data;
                                    ram.we <= 1'b1;
                                    ram.wm <= 2'b00;
                                    ram.req <= 1'b1;
                                    if (first_word) first_word <= 1'b0;
                                    else ram.address <= ram.address + 1'b1;
                                end
                                high_byte <= !high_byte;
                            end
                        end
                    end

                    default: state <= CMD;
                endcase
            end
        end
    end

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        $rose(stream.rd_ready) |-> stream.rd_valid);

    // Memory recovery window must be respected
    a_req_not_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(ram.req) |-> !ram.busy);
endmodule

`default_nettype wire

// ==== verilog/launch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module launch_regs (
    input logic clk,
    input logic reset,
    input loader_pkg::map_ctrl_t launch_word,
    input logic launch_strobe,
    output loader_pkg::map_ctrl_t map_ctrl,
    output logic map_ctrl_req,
    input logic map_ctrl_ack
);
    import loader_pkg::*;

    logic [1:0] ack_sync; // ack arrives from the mapper clock domain
    logic ack_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], map_ctrl_ack};
        end
    end

    // Request and ack level-equal means the mapper has caught up
    assign ack_done = (map_ctrl_req == ack_sync[1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            map_ctrl <= '0;
            map_ctrl_req <= 1'b0;
        end else if (launch_strobe) begin
            map_ctrl <= launch_word;
            if (ack_done) map_ctrl_req <= !map_ctrl_req;
        end
    end
endmodule

`default_nettype wire

// ==== verilog/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loader_cfg.svh"

module word_ram (
    input logic clk,
    input logic reset,
    sdram_port_if.memory ram,
    input loader_pkg::waddr_t rd_addr,
    output loader_pkg::word_t rd_data
);
    import loader_pkg::*;

    localparam int AW = `RAM_AW;
    localparam int BUSY = `RAM_BUSY_CYCLES;
    localparam int BW = $clog2(BUSY + 1);

    word_t mem [2**AW];
    logic [BW-1:0] busy_cnt;

    always_ff @(posedge clk) begin
        if (ram.req && ram.we) begin
            if (!ram.wm[1]) mem[ram.address[AW-1:0]][15:8] <= ram.data_write[15:8];
            if (!ram.wm[0]) mem[ram.address[AW-1:0]][7:0] <= ram.data_write[7:0];
        end
        rd_data <= mem[rd_addr[AW-1:0]]; // upper address bits wrap
    end

    // Recovery window stands in for SDRAM write-to-write spacing
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (ram.req) begin
            busy_cnt <= BW'(BUSY);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign ram.busy = (busy_cnt != '0);

    a_req_outside_busy: assert property (@(posedge clk) disable iff (reset)
        ram.req |-> !ram.busy);
endmodule

`default_nettype wire

// ==== verilog/loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_top (
    input logic clk,
    input logic reset,

    input logic qspi_sck,
    input logic qspi_cs_n,
    input logic [3:0] qspi_io,

    output loader_pkg::map_ctrl_t map_ctrl,
    output logic map_ctrl_req,
    input logic map_ctrl_ack, // asynchronous

    input loader_pkg::waddr_t mem_rd_addr,
    output loader_pkg::word_t mem_rd_data
);
    import loader_pkg::*;

    byte_stream_if stream_if ();
    sdram_port_if ram_if ();

    map_ctrl_t launch_word;
    logic launch_strobe;

    qspi_byte_rx u_rx (
        .clk(clk),
        .reset(reset),
        .qspi_sck(qspi_sck),
        .qspi_cs_n(qspi_cs_n),
        .qspi_io(qspi_io),
        .stream(stream_if.producer)
    );

    cmd_decoder u_dec (
        .clk(clk),
        .reset(reset),
        .stream(stream_if.consumer),
        .ram(ram_if.controller),
        .launch_word(launch_word),
        .launch_strobe(launch_strobe)
    );

    launch_regs u_launch (
        .clk(clk),
        .reset(reset),
        .launch_word(launch_word),
        .launch_strobe(launch_strobe),
        .map_ctrl(map_ctrl),
        .map_ctrl_req(map_ctrl_req),
        .map_ctrl_ack(map_ctrl_ack)
    );

    word_ram u_ram (
        .clk(clk),
        .reset(reset),
        .ram(ram_if.memory),
        .rd_addr(mem_rd_addr),
        .rd_data(mem_rd_data)
    );
endmodule

`default_nettype wire

// ==== tb/loader_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loader_cfg.svh"

module loader_checker #(
    parameter int FRAME_MAX = 40
) (
    input logic clk,
    input logic reset,
    input loader_pkg::map_ctrl_t map_ctrl,
    input logic map_ctrl_req,
    input logic map_ctrl_ack,
    output loader_pkg::waddr_t mem_rd_addr,
    input loader_pkg::word_t mem_rd_data
);
    import loader_pkg::*;

    localparam int MEM_WORDS = 2 ** `RAM_AW;
    localparam int SETTLE_CYCLES = 64;

    word_t ref_mem [MEM_WORDS];
    bit ref_written [MEM_WORDS];
    map_ctrl_t exp_ctrl = '0;
    logic exp_req = 1'b0;
    int exp_toggles = 0;
    int toggle_count = 0;
    logic req_q;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int errors_before = 0;

    initial mem_rd_addr = '0;

    // Every edge of map_ctrl_req counts as one request
    always @(posedge clk) begin
        if (reset) begin
            toggle_count <= 0;
        end else if (map_ctrl_req !== req_q) begin
            toggle_count <= toggle_count + 1;
        end
        req_q <= map_ctrl_req;
    end

    // Link carries a byte address, so bit 0 and bit 23 drop out
    function automatic waddr_t frame_word_addr(input byte_t a0, input byte_t a1, input byte_t a2);
        logic [23:0] byte_addr;
        byte_addr = {a0, a1, a2};
        return waddr_t'(byte_addr >> 1);
    endfunction

    function automatic int mem_index(input waddr_t base, input int word_idx);
        waddr_t a;
        a = base + waddr_t'(word_idx);
        return int'(a[`RAM_AW-1:0]); // memory keeps only the low bits
    endfunction

    // Called before the frame goes out, while the ack level is settled
    task automatic apply_frame(input byte_t bytes [FRAME_MAX], input int len);
        waddr_t base;
        int nwords;
        int idx;
        case (bytes[0])
            `CMD_WRITE: begin
                base = frame_word_addr(bytes[1], bytes[2], bytes[3]);
                nwords = (len - 4) / 2; // trailing odd byte never written
                for (int w = 0; w < nwords; w++) begin
                    idx = mem_index(base, w);
                    ref_mem[idx] = {bytes[4 + 2 * w], bytes[5 + 2 * w]};
                    ref_written[idx] = 1'b1;
                end
            end
            `CMD_LAUNCH: begin
                exp_ctrl = {bytes[1], bytes[2], bytes[3]};
                if (exp_req == map_ctrl_ack) begin
                    exp_req = !exp_req;
                    exp_toggles++;
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_word(input waddr_t addr, output word_t data);
        @(posedge clk);
        mem_rd_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = mem_rd_data;
    endtask

    task automatic check_launch();
        int waited;
        waited = 0;
        @(negedge clk);
        while (toggle_count != exp_toggles && waited < SETTLE_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_value("map_ctrl_req toggle count", 32'(toggle_count), 32'(exp_toggles));
        check_value("map_ctrl", 32'(map_ctrl), 32'(exp_ctrl));
        check_value("map_ctrl_req", 32'(map_ctrl_req), 32'(exp_req));
    endtask

    task automatic check_memory();
        word_t got;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (ref_written[i]) begin
                read_word(waddr_t'(i), got);
                check_value($sformatf("mem[%03h]", i), 32'(got), 32'(ref_mem[i]));
            end
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_count, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic report_summary();
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    endtask
endmodule

`default_nettype wire

// ==== tb/loader_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loader_cfg.svh"

module loader_tb;
    import loader_pkg::*;

    localparam int SCK_HALF = 4; // 8 clk per SCK period
    localparam int IDLE_CYCLES = 16;
    localparam int FRAME_MAX = 40;
    localparam int TOTAL_BYTES = 240; // bound on bytes sent over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 2 * (2 * SCK_HALF) * 4 + 8000;

    logic clk;
    logic reset;
    logic qspi_sck;
    logic qspi_cs_n;
    logic [3:0] qspi_io;
    map_ctrl_t map_ctrl;
    logic map_ctrl_req;
    logic map_ctrl_ack;
    waddr_t mem_rd_addr;
    word_t mem_rd_data;

    logic [31:0] lfsr;
    logic ack_hold; // keeps the responder from answering
    byte_t frame [FRAME_MAX];
    int frame_len;

    loader_top u_dut (
        .clk(clk),
        .reset(reset),
        .qspi_sck(qspi_sck),
        .qspi_cs_n(qspi_cs_n),
        .qspi_io(qspi_io),
        .map_ctrl(map_ctrl),
        .map_ctrl_req(map_ctrl_req),
        .map_ctrl_ack(map_ctrl_ack),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_data(mem_rd_data)
    );

    loader_checker #(.FRAME_MAX(FRAME_MAX)) u_chk (
        .clk(clk),
        .reset(reset),
        .map_ctrl(map_ctrl),
        .map_ctrl_req(map_ctrl_req),
        .map_ctrl_ack(map_ctrl_ack),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_data(mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic send_nibble(input logic [3:0] nib);
        qspi_io <= nib;
        repeat (SCK_HALF) @(posedge clk);
        qspi_sck <= 1'b1;
        repeat (SCK_HALF) @(posedge clk);
        qspi_sck <= 1'b0;
    endtask

    task automatic send_frame();
        qspi_cs_n <= 1'b0;
        repeat (4) @(posedge clk);
        for (int i = 0; i < frame_len; i++) begin
            send_nibble(frame[i][7:4]); // upper nibble first
            send_nibble(frame[i][3:0]);
        end
        repeat (SCK_HALF) @(posedge clk);
        qspi_cs_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic run_frame();
        u_chk.apply_frame(frame, frame_len);
        send_frame();
        u_chk.check_launch();
        u_chk.check_memory();
        @(posedge clk);
    endtask

    task automatic write_frame(input logic [23:0] addr, input int nwords, input bit odd);
        frame[0] = `CMD_WRITE;
        frame[1] = addr[23:16];
        frame[2] = addr[15:8];
        frame[3] = addr[7:0];
        frame_len = 4 + 2 * nwords + int'(odd);
        for (int i = 4; i < frame_len; i++) begin
            frame[i] = byte_t'(rand_bits(8));
        end
        run_frame();
    endtask

    task automatic launch_frame(input map_ctrl_t word);
        frame[0] = `CMD_LAUNCH;
        frame[1] = word[23:16];
        frame[2] = word[15:8];
        frame[3] = word[7:0];
        frame_len = 4;
        run_frame();
    endtask

    task automatic wait_ack_idle();
        @(negedge clk);
        while (map_ctrl_ack != map_ctrl_req) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk); // ack through the two sync flops
    endtask

    // Mapper side of the toggle handshake
    initial begin : ack_responder
        int delay;
        forever begin
            @(negedge clk);
            if (!ack_hold && map_ctrl_ack != map_ctrl_req) begin
                delay = 4 + int'(rand_bits(5)) % 17;
                repeat (delay) @(posedge clk);
                map_ctrl_ack <= !map_ctrl_ack;
                @(posedge clk);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        byte_t cmd;
        logic [23:0] base_addr;
        reset = 1'b1;
        qspi_sck = 1'b0;
        qspi_cs_n = 1'b1;
        qspi_io = 4'h0;
        map_ctrl_ack = 1'b0;
        ack_hold = 1'b0;
        lfsr = 32'h8b97_75cb;
        frame_len = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        u_chk.check_launch();
        @(posedge clk);
        launch_frame(map_ctrl_t'(rand_bits(24)));
        u_chk.end_test("reset and first launch");

        base_addr = 24'(rand_bits(24));
        write_frame(base_addr, int'(rand_bits(4)) + 1, 1'b0);
        u_chk.end_test("write burst");

        wait_ack_idle();
        ack_hold = 1'b1;
        launch_frame(map_ctrl_t'(rand_bits(24)));
        launch_frame(map_ctrl_t'(rand_bits(24))); // previous request still open
        ack_hold = 1'b0;
        wait_ack_idle();
        u_chk.end_test("launch handshake");

        cmd = byte_t'(rand_bits(8));
        if (cmd == `CMD_WRITE || cmd == `CMD_LAUNCH) cmd = cmd + 8'h10;
        frame[0] = cmd;
        // Burst address again so a stray write lands on checked words
        frame[1] = base_addr[23:16];
        frame[2] = base_addr[15:8];
        frame[3] = base_addr[7:0];
        frame_len = 6 + int'(rand_bits(3));
        for (int i = 4; i < frame_len; i++) begin
            frame[i] = byte_t'(rand_bits(8));
        end
        run_frame();
        write_frame(24'(rand_bits(24)), int'(rand_bits(4)) + 1, 1'b0);
        u_chk.end_test("unknown command");

        base_addr = 24'(rand_bits(24));
        write_frame(base_addr, 16, 1'b0); // known words behind the trailing byte
        write_frame(base_addr, int'(rand_bits(3)) + 1, 1'b1);
        write_frame(24'(rand_bits(24)), int'(rand_bits(4)) + 1, 1'b0);
        u_chk.end_test("odd byte count");

        // Upper word address bits set, low bits at 3FE so the burst wraps
        write_frame({1'b0, 7'h40 | 7'(rand_bits(7)), 5'(rand_bits(5)), 3'b111, 7'h7e,
                     1'(rand_bits(1))}, 4, 1'b0);
        u_chk.end_test("address wrap");

        u_chk.report_summary();
        if (u_chk.error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/loader_pkg.sv
verilog/byte_stream_if.sv
verilog/sdram_port_if.sv
verilog/qspi_byte_rx.sv
verilog/cmd_decoder.sv
verilog/launch_regs.sv
verilog/word_ram.sv
verilog/loader_top.sv
tb/loader_checker.sv
tb/loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module loader_tb -f sim.f -o loader_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/loader_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
